// ==== hdl/debounce.sv ====
module debounce #(
   parameter int WIDTH     = 21,
   parameter int DB_CYCLES = 8
) (
   input  logic             clk,
   input  logic             i_rst_n,
   input  logic [WIDTH-1:0] i_raw,
   output logic [WIDTH-1:0] o_clean
);

   localparam int CNT_W = $clog2(DB_CYCLES + 1);

   logic [WIDTH-1:0] sync1;
   logic [WIDTH-1:0] sync2;
   logic [WIDTH-1:0] clean_q;
   logic [CNT_W-1:0] cnt [WIDTH];

   // Two-flop synchronizer
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         sync1 <= '0;
         sync2 <= '0;
      end else begin
         sync1 <= i_raw;
         sync2 <= sync1;
      end
   end

   // Per bit: count while the input disagrees, restart when it agrees again
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         clean_q <= '0;
         for (int i = 0; i < WIDTH; i++) begin
            cnt[i] <= '0;
         end
      end else begin
         for (int i = 0; i < WIDTH; i++) begin
            if (sync2[i] == clean_q[i]) begin
               cnt[i] <= '0;
            end else if (cnt[i] == CNT_W'(DB_CYCLES - 1)) begin
               clean_q[i] <= sync2[i];
               cnt[i]     <= '0;
            end else begin
               cnt[i] <= cnt[i] + 1'b1;
            end
         end
      end
   end

   assign o_clean = clean_q;

endmodule

// ==== hdl/gpio_port.sv ====
module gpio_port #(
   parameter int WIDTH = 16
) (
   input  logic                clk,
   input  logic                i_rst_n,
   input  periph_pkg::wb_req_t i_req,
   output periph_pkg::wb_rsp_t o_rsp,
   input  logic [WIDTH-1:0]    i_in,
   output logic [WIDTH-1:0]    o_out,
   output logic [WIDTH-1:0]    o_oe
);
   import periph_pkg::*;

   logic [WIDTH-1:0] out_q;
   logic [WIDTH-1:0] oe_q;
   logic             ack_q;
   logic             req_go;
   reg_off_t         off;
   wb_data_t         rd_data;

   assign off    = i_req.adr[5:2];
   assign req_go = i_req.cyc && i_req.stb && !ack_q;

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         ack_q <= 1'b0;
         out_q <= '0;
         oe_q  <= '0;
      end else begin
         ack_q <= req_go;
         // REG_IN and unused offsets ignore writes
         if (req_go && i_req.we) begin
            case (off)
               REG_OUT: out_q <= i_req.dat[WIDTH-1:0];
               REG_OE:  oe_q  <= i_req.dat[WIDTH-1:0];
               default: ;
            endcase
         end
      end
   end

   // Read mux, zero-extended to the bus width
   always_comb begin
      case (off)
         REG_OUT: rd_data = wb_data_t'(out_q);
         REG_OE:  rd_data = wb_data_t'(oe_q);
         REG_IN:  rd_data = wb_data_t'(i_in);
         default: rd_data = '0;
      endcase
   end

   // Data only during a read ack
   always_comb begin
      o_rsp.ack = ack_q;
      o_rsp.dat = (ack_q && !i_req.we) ? rd_data : '0;
   end

   assign o_out = out_q;
   assign o_oe  = oe_q;

endmodule

// ==== hdl/periph_pkg.sv ====
package periph_pkg;

   // ************************************************************************
   // Bus widths and structs
   // ************************************************************************

   // Bits 7:6 pick the slot, bits 5:2 the register
   typedef logic [7:0]  wb_addr_t;
   typedef logic [31:0] wb_data_t;
   typedef logic [3:0]  reg_off_t;

   typedef struct packed {
      logic     cyc;
      logic     stb;
      logic     we;
      wb_addr_t adr;
      wb_data_t dat;
   } wb_req_t;

   typedef struct packed {
      logic     ack;
      wb_data_t dat;
   } wb_rsp_t;

   // ************************************************************************
   // Address map
   // ************************************************************************

   localparam logic [1:0] SLOT_GPIO = 2'd0;
   localparam logic [1:0] SLOT_PB   = 2'd1;
   localparam logic [1:0] SLOT_SEG  = 2'd2;
   localparam logic [1:0] SLOT_NONE = 2'd3;

   // GPIO bank registers
   localparam reg_off_t REG_OUT = 4'd0;
   localparam reg_off_t REG_OE  = 4'd1;
   localparam reg_off_t REG_IN  = 4'd2;

   // Display registers
   localparam reg_off_t REG_DIGITS = 4'd0;
   localparam reg_off_t REG_ENABLE = 4'd1;
   localparam reg_off_t REG_DP     = 4'd2;

   localparam int PB_W       = 5;
   localparam int NUM_DIGITS = 8;

   typedef logic [2:0] digit_idx_t;
   // Active low, segment a in bit 0
   typedef logic [6:0] seg_t;

endpackage

// ==== hdl/periph_top.sv ====
module periph_top #(
   parameter int GPIO_W    = 16,
   parameter int DB_CYCLES = 8,
   parameter int SCAN_DIV  = 4
) (
   input  logic                            clk,
   input  logic                            i_rst_n,
   input  periph_pkg::wb_req_t             i_wb,
   output periph_pkg::wb_rsp_t             o_wb,
   input  logic [GPIO_W-1:0]               i_sw,
   input  logic [periph_pkg::PB_W-1:0]     i_pb,
   output logic [GPIO_W-1:0]               o_gpio_out,
   output logic [GPIO_W-1:0]               o_gpio_oe,
   output logic [periph_pkg::NUM_DIGITS-1:0] o_an,
   output periph_pkg::seg_t                o_seg,
   output logic                            o_dp
);
   import periph_pkg::*;

   wb_req_t gpio_req;
   wb_req_t pb_req;
   wb_req_t seg_req;
   wb_rsp_t gpio_rsp;
   wb_rsp_t pb_rsp;
   wb_rsp_t seg_rsp;

   logic [GPIO_W-1:0] sw_db;
   logic [PB_W-1:0]   pb_db;

   wb_decoder u_decoder (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_wb       (i_wb),
      .o_gpio_req (gpio_req),
      .o_pb_req   (pb_req),
      .o_seg_req  (seg_req),
      .i_gpio_rsp (gpio_rsp),
      .i_pb_rsp   (pb_rsp),
      .i_seg_rsp  (seg_rsp),
      .o_wb       (o_wb)
   );

   // Switches and buttons share one debouncer
   debounce #(
      .WIDTH     (GPIO_W + PB_W),
      .DB_CYCLES (DB_CYCLES)
   ) u_debounce (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_raw   ({i_pb, i_sw}),
      .o_clean ({pb_db, sw_db})
   );

   // LEDs and switches
   gpio_port #(.WIDTH(GPIO_W)) u_gpio (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_req   (gpio_req),
      .o_rsp   (gpio_rsp),
      .i_in    (sw_db),
      .o_out   (o_gpio_out),
      .o_oe    (o_gpio_oe)
   );

   // Pushbuttons, input only
   gpio_port #(.WIDTH(PB_W)) u_pb (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_req   (pb_req),
      .o_rsp   (pb_rsp),
      .i_in    (pb_db),
      .o_out   (),
      .o_oe    ()
   );

   seg7_scan #(.SCAN_DIV(SCAN_DIV)) u_seg (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_req   (seg_req),
      .o_rsp   (seg_rsp),
      .o_an    (o_an),
      .o_seg   (o_seg),
      .o_dp    (o_dp)
   );

endmodule

// ==== hdl/seg7_scan.sv ====
module seg7_scan #(
   parameter int SCAN_DIV = 4
) (
   input  logic                              clk,
   input  logic                              i_rst_n,
   input  periph_pkg::wb_req_t               i_req,
   output periph_pkg::wb_rsp_t               o_rsp,
   output logic [periph_pkg::NUM_DIGITS-1:0] o_an,
   output periph_pkg::seg_t                  o_seg,
   output logic                              o_dp
);
   import periph_pkg::*;

   localparam int PRE_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;

   wb_data_t              digits_q;
   logic [NUM_DIGITS-1:0] enable_q;
   logic [NUM_DIGITS-1:0] dp_q;
   logic                  ack_q;
   logic                  req_go;
   reg_off_t              off;
   wb_data_t              rd_data;
   logic [PRE_W-1:0]      pre_q;
   digit_idx_t            digit_q;
   logic [3:0]            nibble;

   // Standard hex font, inverted for the active-low segments
   function automatic seg_t hex_to_seg(input logic [3:0] hex);
      seg_t on;
      case (hex)
         4'h0: on = 7'h3f;
         4'h1: on = 7'h06;
         4'h2: on = 7'h5b;
         4'h3: on = 7'h4f;
         4'h4: on = 7'h66;
         4'h5: on = 7'h6d;
         4'h6: on = 7'h7d;
         4'h7: on = 7'h07;
         4'h8: on = 7'h7f;
         4'h9: on = 7'h6f;
         4'ha: on = 7'h77;
         4'hb: on = 7'h7c;
         4'hc: on = 7'h39;
         4'hd: on = 7'h5e;
         4'he: on = 7'h79;
         default: on = 7'h71;
      endcase
      return ~on;
   endfunction

   // ************************************************************************
   // Register bank
   // ************************************************************************

   assign off    = i_req.adr[5:2];
   assign req_go = i_req.cyc && i_req.stb && !ack_q;

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         ack_q    <= 1'b0;
         digits_q <= '0;
         enable_q <= '0;
         dp_q     <= '0;
      end else begin
         ack_q <= req_go;
         if (req_go && i_req.we) begin
            case (off)
               REG_DIGITS: digits_q <= i_req.dat;
               REG_ENABLE: enable_q <= i_req.dat[NUM_DIGITS-1:0];
               REG_DP:     dp_q     <= i_req.dat[NUM_DIGITS-1:0];
               default: ;
            endcase
         end
      end
   end

   always_comb begin
      case (off)
         REG_DIGITS: rd_data = digits_q;
         REG_ENABLE: rd_data = wb_data_t'(enable_q);
         REG_DP:     rd_data = wb_data_t'(dp_q);
         default:    rd_data = '0;
      endcase
      o_rsp.ack = ack_q;
      o_rsp.dat = (ack_q && !i_req.we) ? rd_data : '0;
   end

   // ************************************************************************
   // Digit scanning
   // ************************************************************************

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         pre_q   <= '0;
         digit_q <= '0;
      end else if (pre_q == PRE_W'(SCAN_DIV - 1)) begin
         pre_q   <= '0;
         digit_q <= digit_q + 1'b1;
      end else begin
         pre_q <= pre_q + 1'b1;
      end
   end

   assign nibble = digits_q[4*digit_q +: 4];
   // Anode low only for the current digit, and only when enabled
   assign o_an   = ~(enable_q & (NUM_DIGITS'(1) << digit_q));
   assign o_seg  = hex_to_seg(nibble);
   assign o_dp   = ~dp_q[digit_q];

endmodule

// ==== hdl/wb_decoder.sv ====
module wb_decoder (
   input  logic                clk,
   input  logic                i_rst_n,
   input  periph_pkg::wb_req_t i_wb,
   output periph_pkg::wb_req_t o_gpio_req,
   output periph_pkg::wb_req_t o_pb_req,
   output periph_pkg::wb_req_t o_seg_req,
   input  periph_pkg::wb_rsp_t i_gpio_rsp,
   input  periph_pkg::wb_rsp_t i_pb_rsp,
   input  periph_pkg::wb_rsp_t i_seg_rsp,
   output periph_pkg::wb_rsp_t o_wb
);
   import periph_pkg::*;

   logic [1:0] slot;
   logic       none_ack;

   assign slot = i_wb.adr[7:6];

   // Same request to every slave, strobe only where the slot matches
   always_comb begin
      o_gpio_req     = i_wb;
      o_pb_req       = i_wb;
      o_seg_req      = i_wb;
      o_gpio_req.stb = i_wb.stb && (slot == SLOT_GPIO);
      o_pb_req.stb   = i_wb.stb && (slot == SLOT_PB);
      o_seg_req.stb  = i_wb.stb && (slot == SLOT_SEG);
   end

   // ************************************************************************
   // Unmapped slot
   // ************************************************************************

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         none_ack <= 1'b0;
      end else begin
         none_ack <= i_wb.cyc && i_wb.stb && (slot == SLOT_NONE) && !none_ack;
      end
   end

   // Idle slaves drive zero, so the responses can be ORed
   always_comb begin
      o_wb.ack = i_gpio_rsp.ack | i_pb_rsp.ack | i_seg_rsp.ack | none_ack;
      o_wb.dat = i_gpio_rsp.dat | i_pb_rsp.dat | i_seg_rsp.dat;
   end

endmodule

// ==== project.f ====
hdl/periph_pkg.sv
hdl/wb_decoder.sv
hdl/gpio_port.sv
hdl/debounce.sv
hdl/seg7_scan.sv
hdl/periph_top.sv
sim/tb_periph.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the peripheral testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary -f project.f --top-module tb_periph -o tb_periph --Mdir obj_dir

./obj_dir/tb_periph

// ==== sim/tb_periph.sv ====
module tb_periph;
   import periph_pkg::*;

   localparam int GPIO_W     = 16;
   localparam int DB_CYCLES  = 8;
   localparam int SCAN_DIV   = 4;
   localparam int CLK_PERIOD = 20;
   localparam int N_GPIO     = 8;
   localparam int N_DB       = 6;
   localparam int N_SCAN     = 2;
   localparam int BUS_CYC    = 4;
   localparam int READ_ALL   = 16 * BUS_CYC;
   localparam int SCAN_LEN   = 4 * NUM_DIGITS * SCAN_DIV;
   // Each poll reads both banks back to back in six cycles
   localparam int N_POLL     = (DB_CYCLES / 2 + DB_CYCLES + 4) / 6 + 1;
   localparam int TEST_CYCLES = 8 + 4 * READ_ALL + N_GPIO * 4 * BUS_CYC
      + N_DB * (2 * DB_CYCLES + 16 + 4 * BUS_CYC)
      + N_SCAN * (SCAN_LEN + 4 * BUS_CYC) + 8 * BUS_CYC;

   // Segments a to g in bits 0 to 6, lit high
   localparam logic [6:0] FONT [16] = '{7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d,
      7'h07, 7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71};

   logic                  clk;
   logic                  rst_n;
   wb_req_t               bus_req;
   wb_rsp_t               bus_rsp;
   logic [GPIO_W-1:0]     sw_in;
   logic [PB_W-1:0]       pb_in;
   logic [GPIO_W-1:0]     gpio_out;
   logic [GPIO_W-1:0]     gpio_oe;
   logic [NUM_DIGITS-1:0] an;
   seg_t                  seg;
   logic                  dp;

   // Expected register contents
   logic [GPIO_W-1:0]     exp_out;
   logic [GPIO_W-1:0]     exp_oe;
   logic [GPIO_W-1:0]     exp_sw;
   logic [PB_W-1:0]       exp_pb_out;
   logic [PB_W-1:0]       exp_pb_oe;
   logic [PB_W-1:0]       exp_pb;
   wb_data_t              exp_digits;
   logic [NUM_DIGITS-1:0] exp_en;
   logic [NUM_DIGITS-1:0] exp_dp;
   logic                  scan_on;
   logic [NUM_DIGITS-1:0] seen;

   periph_top u_dut (
      .clk        (clk),
      .i_rst_n    (rst_n),
      .i_wb       (bus_req),
      .o_wb       (bus_rsp),
      .i_sw       (sw_in),
      .i_pb       (pb_in),
      .o_gpio_out (gpio_out),
      .o_gpio_oe  (gpio_oe),
      .o_an       (an),
      .o_seg      (seg),
      .o_dp       (dp)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      #(2 * TEST_CYCLES * CLK_PERIOD);
      fail_run("timeout, the test sequence did not finish in time");
   end

   // ************************************************************************
   // Reference model
   // ************************************************************************

   function automatic wb_addr_t reg_addr(input logic [1:0] slot, input reg_off_t off);
      return {slot, off, 2'b00};
   endfunction

   function automatic seg_t seg_ref(input logic [3:0] hex);
      return ~FONT[hex];
   endfunction

   function automatic wb_data_t reg_ref(input wb_addr_t adr);
      reg_off_t off;
      off = adr[5:2];
      case (adr[7:6])
         SLOT_GPIO: begin
            if (off == REG_OUT) return 32'(exp_out);
            if (off == REG_OE) return 32'(exp_oe);
            if (off == REG_IN) return 32'(exp_sw);
         end
         SLOT_PB: begin
            if (off == REG_OUT) return 32'(exp_pb_out);
            if (off == REG_OE) return 32'(exp_pb_oe);
            if (off == REG_IN) return 32'(exp_pb);
         end
         SLOT_SEG: begin
            if (off == REG_DIGITS) return exp_digits;
            if (off == REG_ENABLE) return 32'(exp_en);
            if (off == REG_DP) return 32'(exp_dp);
         end
         default: ;
      endcase
      return '0;
   endfunction

   function automatic void model_write(input wb_addr_t adr, input wb_data_t dat);
      reg_off_t off;
      off = adr[5:2];
      case (adr[7:6])
         SLOT_GPIO: begin
            if (off == REG_OUT) exp_out = dat[GPIO_W-1:0];
            if (off == REG_OE) exp_oe = dat[GPIO_W-1:0];
         end
         SLOT_PB: begin
            if (off == REG_OUT) exp_pb_out = dat[PB_W-1:0];
            if (off == REG_OE) exp_pb_oe = dat[PB_W-1:0];
         end
         SLOT_SEG: begin
            if (off == REG_DIGITS) exp_digits = dat;
            if (off == REG_ENABLE) exp_en = dat[NUM_DIGITS-1:0];
            if (off == REG_DP) exp_dp = dat[NUM_DIGITS-1:0];
         end
         default: ;
      endcase
   endfunction

   // ************************************************************************
   // Checks and bus tasks
   // ************************************************************************

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("*** TEST FAILED ***");
      $fatal(1);
   endtask

   task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act) begin
         fail_run($sformatf("ERR %s: expected %h, actual %h", name, exp, act));
      end
   endtask

   task automatic bus_cycle(input wb_addr_t adr, input logic we, input wb_data_t wdat,
                            output wb_data_t rdat);
      @(posedge clk);
      bus_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
      @(negedge clk);
      if (bus_rsp.ack) fail_run($sformatf("ack came too early at address %h", adr));
      @(negedge clk);
      if (!bus_rsp.ack) fail_run($sformatf("no ack one cycle after request at %h", adr));
      rdat = bus_rsp.dat;
      @(posedge clk);
      bus_req <= '0;
   endtask

   task automatic wb_write(input wb_addr_t adr, input wb_data_t dat);
      wb_data_t ignored;
      bus_cycle(adr, 1'b1, dat, ignored);
   endtask

   task automatic wb_read(input wb_addr_t adr, output wb_data_t dat);
      bus_cycle(adr, 1'b0, '0, dat);
   endtask

   task automatic write_reg(input wb_addr_t adr, input wb_data_t dat);
      wb_write(adr, dat);
      model_write(adr, dat);
   endtask

   task automatic check_regs(input string name);
      wb_data_t rd;
      wb_addr_t adr;
      for (int s = 0; s < 4; s++) begin
         for (int r = 0; r < 4; r++) begin
            adr = reg_addr(s[1:0], r[3:0]);
            wb_read(adr, rd);
            check($sformatf("%s read %h", name, adr), reg_ref(adr), rd);
         end
      end
      @(negedge clk);
      check({name, " gpio out pins"}, 32'(exp_out), 32'(gpio_out));
      check({name, " gpio oe pins"}, 32'(exp_oe), 32'(gpio_oe));
   endtask

   task automatic apply_inputs(input logic [GPIO_W-1:0] sw, input logic [PB_W-1:0] pb,
                               input int hold);
      @(posedge clk);
      sw_in <= sw;
      pb_in <= pb;
      repeat (hold - 1) @(posedge clk);
   endtask

   task automatic check_inputs(input string name);
      wb_data_t rd;
      wb_read(reg_addr(SLOT_GPIO, REG_IN), rd);
      check({name, " switches"}, 32'(exp_sw), rd);
      wb_read(reg_addr(SLOT_PB, REG_IN), rd);
      check({name, " buttons"}, 32'(exp_pb), rd);
   endtask

   // Back-to-back reads, one sample every three cycles
   task automatic poll_inputs(input string name, input int polls);
      repeat (polls) check_inputs(name);
   endtask

   // Display monitor, sampled between clock edges
   always @(negedge clk) begin
      if (scan_on) begin
         if ($countones(~an) > 1) fail_run("more than one display digit lit at once");
         for (int i = 0; i < NUM_DIGITS; i++) begin
            if (!an[i]) begin
               check($sformatf("scan enable %0d", i), 32'(1'b1), 32'(exp_en[i]));
               check($sformatf("scan seg %0d", i), 32'(seg_ref(exp_digits[4*i +: 4])),
                     32'(seg));
               check($sformatf("scan dp %0d", i), 32'(exp_dp[i]), 32'(!dp));
               seen[i] = 1'b1;
            end
         end
      end
   end

   // ************************************************************************
   // Test sequence
   // ************************************************************************

   initial begin
      logic [GPIO_W-1:0] sw_val;
      logic [PB_W-1:0]   pb_val;
      rst_n      = 1'b0;
      bus_req    = '0;
      sw_in      = '0;
      pb_in      = '0;
      exp_out    = '0;
      exp_oe     = '0;
      exp_sw     = '0;
      exp_pb_out = '0;
      exp_pb_oe  = '0;
      exp_pb     = '0;
      exp_digits = '0;
      exp_en     = '0;
      exp_dp     = '0;
      scan_on    = 1'b0;
      seen       = '0;
      void'($urandom(32'h72b8));
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;

      @(negedge clk);
      check("reset anodes", 32'hff, 32'(an));
      check_regs("reset");

      for (int n = 0; n < N_GPIO; n++) begin
         write_reg(reg_addr(SLOT_GPIO, REG_OUT), $urandom);
         write_reg(reg_addr(SLOT_GPIO, REG_OE), $urandom);
         // Input register is read-only
         write_reg(reg_addr(SLOT_GPIO, REG_IN), $urandom);
         @(negedge clk);
         check("gpio out pins", 32'(exp_out), 32'(gpio_out));
         check("gpio oe pins", 32'(exp_oe), 32'(gpio_oe));
      end
      check_regs("gpio");

      for (int n = 0; n < N_DB; n++) begin
         sw_val = GPIO_W'($urandom);
         pb_val = PB_W'($urandom);
         apply_inputs(sw_val, pb_val, DB_CYCLES + 4);
         exp_sw = sw_val;
         exp_pb = pb_val;
         check_inputs("debounced");
         // Short bounce to the opposite level, polled while it passes
         fork
            begin
               apply_inputs(~sw_val, ~pb_val, DB_CYCLES / 2 - 1);
               apply_inputs(sw_val, pb_val, DB_CYCLES + 4);
            end
            poll_inputs("glitch", N_POLL);
         join
      end

      for (int n = 0; n < N_SCAN; n++) begin
         write_reg(reg_addr(SLOT_SEG, REG_DIGITS), $urandom);
         write_reg(reg_addr(SLOT_SEG, REG_ENABLE), $urandom);
         write_reg(reg_addr(SLOT_SEG, REG_DP), $urandom);
         seen    = '0;
         scan_on = 1'b1;
         repeat (SCAN_LEN) @(posedge clk);
         scan_on = 1'b0;
         check("scan coverage", 32'(exp_en), 32'(seen));
      end

      // Unmapped slot, unused offsets and the button bank
      write_reg(reg_addr(SLOT_NONE, REG_OUT), $urandom);
      write_reg(reg_addr(SLOT_NONE, 4'd5), $urandom);
      write_reg(reg_addr(SLOT_PB, REG_OUT), $urandom);
      write_reg(reg_addr(SLOT_PB, REG_OE), $urandom);
      write_reg(reg_addr(SLOT_GPIO, 4'd3), $urandom);
      write_reg(reg_addr(SLOT_SEG, 4'd7), $urandom);
      check_regs("slot decode");

      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule
